// ==== logic/bpu_pkg.sv ====
package bpu_pkg;

	// Branch target cache geometry
	localparam int unsigned BTC_SETS = 8;
	localparam int unsigned BTC_INDEX_BITS = 3;
	localparam int unsigned BTC_TAG_BITS = 27;

	// Width of the recency aging timer
	localparam int unsigned LRU_AGE_BITS = 8;

	// Return address stack geometry
	localparam int unsigned RAS_DEPTH = 4;
	localparam int unsigned RAS_PTR_BITS = 2;

	typedef logic [31:0] addr_t;

	typedef enum logic [1:0] {
		BR_COND = 2'd0,
		BR_CALL = 2'd1,
		BR_RET = 2'd2
	} branch_kind_e;

	// Recency ladder, EMPTY marks an invalid entry
	typedef enum logic [1:0] {
		LRU_EMPTY = 2'd0,
		LRU_OLD = 2'd1,
		LRU_MID = 2'd2,
		LRU_NEW = 2'd3
	} lru_state_e;

	typedef struct packed {
		logic valid;
		addr_t pc;
	} search_req_t;

	typedef struct packed {
		logic valid;
		addr_t pc;
		logic taken;
		branch_kind_e kind;
		addr_t target;
	} update_req_t;

	// Taken is the counter verdict of the hit entry
	typedef struct packed {
		logic hit;
		logic taken;
		branch_kind_e kind;
		addr_t target;
	} btc_result_t;

	typedef struct packed {
		logic valid;
		logic hit;
		logic taken;
		branch_kind_e kind;
		addr_t next_pc;
	} prediction_t;

endpackage

// ==== logic/branch_target_cache.sv ====
module branch_target_cache (
	input logic iCLOCK,
	input logic inRESET,
	input logic flush,
	input bpu_pkg::search_req_t search,
	input bpu_pkg::update_req_t update,
	output bpu_pkg::btc_result_t lookup
);
	import bpu_pkg::*;

	localparam int unsigned WAYS = 2;

	typedef logic [BTC_INDEX_BITS-1:0] index_t;
	typedef logic [BTC_TAG_BITS-1:0] tag_t;

	// Per-way storage
	tag_t tag_q [WAYS][BTC_SETS];
	lru_state_e state_q [WAYS][BTC_SETS];
	logic [1:0] ctr_q [WAYS][BTC_SETS];
	branch_kind_e kind_q [WAYS][BTC_SETS];
	addr_t target_q [WAYS][BTC_SETS];

	logic [LRU_AGE_BITS-1:0] age_timer_q;
	logic age_tick;

	// Search side
	index_t s_idx;
	tag_t s_tag;
	logic [WAYS-1:0] s_match;
	logic s_hit;
	logic s_way;

	// Update side
	index_t u_idx;
	tag_t u_tag;
	logic [WAYS-1:0] u_match;
	logic u_hit;
	logic u_way;
	logic u_write;
	logic [1:0] u_ctr_next;

	function automatic logic way_match(tag_t req_tag, tag_t way_tag, lru_state_e st);
		return (st != LRU_EMPTY) && (req_tag == way_tag);
	endfunction

	// Empty ways first, then the less recent one, way 0 on a tie
	function automatic logic pick_victim(lru_state_e st0, lru_state_e st1);
		logic way;
		if (st0 == LRU_EMPTY) begin
			way = 1'b0;
		end else if (st1 == LRU_EMPTY) begin
			way = 1'b1;
		end else if (st0 <= st1) begin
			way = 1'b0;
		end else begin
			way = 1'b1;
		end
		return way;
	endfunction

	// Saturating 2-bit direction counter
	function automatic logic [1:0] ctr_step(logic [1:0] ctr, logic taken);
		logic [1:0] next;
		if (taken) begin
			next = (ctr == 2'd3) ? ctr : ctr + 2'd1;
		end else begin
			next = (ctr == 2'd0) ? ctr : ctr - 2'd1;
		end
		return next;
	endfunction

	function automatic lru_state_e lru_bump(lru_state_e st);
		lru_state_e next;
		case (st)
			LRU_OLD: next = LRU_MID;
			LRU_MID: next = LRU_NEW;
			default: next = st;
		endcase
		return next;
	endfunction

	// Aging never drops an entry to EMPTY
	function automatic lru_state_e lru_age(lru_state_e st);
		lru_state_e next;
		case (st)
			LRU_NEW: next = LRU_MID;
			LRU_MID: next = LRU_OLD;
			default: next = st;
		endcase
		return next;
	endfunction

	assign s_idx = search.pc[BTC_INDEX_BITS+1:2];
	assign s_tag = search.pc[31:BTC_INDEX_BITS+2];
	assign u_idx = update.pc[BTC_INDEX_BITS+1:2];
	assign u_tag = update.pc[31:BTC_INDEX_BITS+2];

	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			s_match[w] = way_match(s_tag, tag_q[w][s_idx], state_q[w][s_idx]);
			u_match[w] = way_match(u_tag, tag_q[w][u_idx], state_q[w][u_idx]);
		end
	end

	// Way 0 wins when both ways match
	assign s_hit = search.valid && (|s_match);
	assign s_way = ~s_match[0];
	assign u_hit = |u_match;

	assign u_way = u_hit ? ~u_match[0] : pick_victim(state_q[0][u_idx], state_q[1][u_idx]);
	assign u_write = update.valid && !flush;

	// Fresh entries start weakly biased toward the first outcome
	assign u_ctr_next = u_hit ? ctr_step(ctr_q[u_way][u_idx], update.taken)
		: (update.taken ? 2'd2 : 2'd1);

	assign age_tick = (age_timer_q == {LRU_AGE_BITS{1'b1}});

	always_comb begin
		lookup.hit = s_hit;
		// Counter of 2 or 3 predicts taken
		lookup.taken = s_hit && ctr_q[s_way][s_idx][1];
		lookup.kind = s_hit ? kind_q[s_way][s_idx] : BR_COND;
		lookup.target = s_hit ? target_q[s_way][s_idx] : '0;
	end

	// Recency state per way
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			for (int s = 0; s < BTC_SETS; s++) begin
				for (int w = 0; w < WAYS; w++) begin
					state_q[w][s] <= LRU_EMPTY;
				end
			end
		end else begin
			for (int s = 0; s < BTC_SETS; s++) begin
				for (int w = 0; w < WAYS; w++) begin
					if (flush) begin
						state_q[w][s] <= LRU_EMPTY;
					end else if (u_write && u_idx == index_t'(s) && u_way == 1'(w)) begin
						state_q[w][s] <= LRU_NEW;
					end else if (s_hit && s_idx == index_t'(s) && s_way == 1'(w)) begin
						state_q[w][s] <= lru_bump(state_q[w][s]);
					end else if (age_tick) begin
						state_q[w][s] <= lru_age(state_q[w][s]);
					end
				end
			end
		end
	end

	// Entry payload
	always_ff @(posedge iCLOCK) begin
		if (u_write) begin
			tag_q[u_way][u_idx] <= u_tag;
			ctr_q[u_way][u_idx] <= u_ctr_next;
			kind_q[u_way][u_idx] <= update.kind;
			target_q[u_way][u_idx] <= update.target;
		end
	end

	// Free-running aging timer
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			age_timer_q <= '0;
		end else if (flush) begin
			age_timer_q <= '0;
		end else begin
			age_timer_q <= age_timer_q + 1'b1;
		end
	end

endmodule

// ==== logic/return_stack.sv ====
module return_stack (
	input logic iCLOCK,
	input logic inRESET,
	input logic flush,
	input logic push,
	input logic pop,
	input bpu_pkg::addr_t push_addr,
	output bpu_pkg::addr_t top,
	output logic empty
);
	import bpu_pkg::*;

	localparam logic [RAS_PTR_BITS:0] COUNT_FULL = (RAS_PTR_BITS + 1)'(RAS_DEPTH);

	addr_t entry_q [RAS_DEPTH];
	logic [RAS_PTR_BITS-1:0] top_ptr_q;
	logic [RAS_PTR_BITS:0] count_q;

	logic [RAS_PTR_BITS-1:0] push_ptr;
	logic [RAS_PTR_BITS-1:0] pop_ptr;

	// Pointers wrap around the buffer
	assign push_ptr = top_ptr_q + 1'b1;
	assign pop_ptr = top_ptr_q - 1'b1;

	assign empty = (count_q == '0);
	assign top = entry_q[top_ptr_q];

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			top_ptr_q <= '0;
			count_q <= '0;
		end else if (flush) begin
			top_ptr_q <= '0;
			count_q <= '0;
		end else if (push) begin
			top_ptr_q <= push_ptr;
			// Full stack keeps its count, oldest slot gets reused
			if (count_q != COUNT_FULL) begin
				count_q <= count_q + 1'b1;
			end
		end else if (pop && !empty) begin
			top_ptr_q <= pop_ptr;
			count_q <= count_q - 1'b1;
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (push && !flush) begin
			entry_q[push_ptr] <= push_addr;
		end
	end

endmodule

// ==== logic/fetch_redirect.sv ====
module fetch_redirect (
	input bpu_pkg::search_req_t search,
	input bpu_pkg::btc_result_t lookup,
	input bpu_pkg::addr_t top,
	input logic empty,
	output logic push,
	output logic pop,
	output bpu_pkg::addr_t push_addr,
	output bpu_pkg::prediction_t prediction
);
	import bpu_pkg::*;

	addr_t seq_pc;
	logic active;

	// Fall-through address, also the return address of a call
	assign seq_pc = search.pc + 32'd4;
	assign push_addr = seq_pc;

	// Stack commands only on a real search hit
	assign active = search.valid && lookup.hit;

	always_comb begin
		prediction.valid = search.valid;
		prediction.hit = lookup.hit;
		prediction.kind = lookup.kind;
		prediction.taken = 1'b0;
		prediction.next_pc = seq_pc;
		push = 1'b0;
		pop = 1'b0;
		if (active) begin
			case (lookup.kind)
				BR_COND: begin
					prediction.taken = lookup.taken;
					if (lookup.taken) begin
						prediction.next_pc = lookup.target;
					end
				end
				BR_CALL: begin
					prediction.taken = 1'b1;
					prediction.next_pc = lookup.target;
					push = 1'b1;
				end
				BR_RET: begin
					prediction.taken = 1'b1;
					pop = 1'b1;
					// Cached target is the fallback when the stack ran dry
					prediction.next_pc = empty ? lookup.target : top;
				end
				default: begin
					prediction.taken = 1'b0;
				end
			endcase
		end
	end

endmodule

// ==== logic/branch_predict_unit.sv ====
module branch_predict_unit (
	input logic iCLOCK,
	input logic inRESET,
	input logic flush,
	input bpu_pkg::search_req_t search,
	input bpu_pkg::update_req_t update,
	output bpu_pkg::prediction_t prediction
);
	import bpu_pkg::*;

	btc_result_t lookup;

	// Stack interface
	addr_t stack_top;
	logic stack_empty;
	logic stack_push;
	logic stack_pop;
	addr_t stack_push_addr;

	branch_target_cache btc_inst (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.flush(flush),
		.search(search),
		.update(update),
		.lookup(lookup)
	);

	return_stack ras_inst (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.flush(flush),
		.push(stack_push),
		.pop(stack_pop),
		.push_addr(stack_push_addr),
		.top(stack_top),
		.empty(stack_empty)
	);

	// Combines cache verdict and stack top into the next fetch pc
	fetch_redirect redirect_inst (
		.search(search),
		.lookup(lookup),
		.top(stack_top),
		.empty(stack_empty),
		.push(stack_push),
		.pop(stack_pop),
		.push_addr(stack_push_addr),
		.prediction(prediction)
	);

endmodule

// ==== testbench/bpu_model.svh ====
`ifndef BPU_MODEL_SVH
`define BPU_MODEL_SVH

// Cache mirror, indexed [way][set]
logic [BTC_TAG_BITS-1:0] m_tag [2][BTC_SETS];
lru_state_e m_state [2][BTC_SETS];
int m_ctr [2][BTC_SETS];
branch_kind_e m_kind [2][BTC_SETS];
addr_t m_target [2][BTC_SETS];
int m_timer;

// Stack mirror
addr_t m_stack [RAS_DEPTH];
int m_top;
int m_count;

function automatic void clear_model();
	for (int i = 0; i < BTC_SETS; i++) begin
		m_state[0][i] = LRU_EMPTY;
		m_state[1][i] = LRU_EMPTY;
	end
	m_timer = 0;
	m_top = 0;
	m_count = 0;
endfunction

// Way 0 is searched first, empty ways never match
function automatic int find_way(addr_t pc);
	int idx;
	idx = int'(pc[4:2]);
	for (int w = 0; w < 2; w++) begin
		if (m_state[w][idx] != LRU_EMPTY && m_tag[w][idx] == pc[31:5]) begin
			return w;
		end
	end
	return -1;
endfunction

function automatic prediction_t expect_prediction(search_req_t s);
	prediction_t p;
	int w;
	int idx;
	idx = int'(s.pc[4:2]);
	w = s.valid ? find_way(s.pc) : -1;
	p.valid = s.valid;
	p.hit = 1'b0;
	p.taken = 1'b0;
	p.kind = BR_COND;
	p.next_pc = s.pc + 32'd4;
	if (w >= 0) begin
		p.hit = 1'b1;
		p.kind = m_kind[w][idx];
		if (p.kind == BR_CALL) begin
			p.taken = 1'b1;
			p.next_pc = m_target[w][idx];
		end else if (p.kind == BR_RET) begin
			p.taken = 1'b1;
			p.next_pc = (m_count == 0) ? m_target[w][idx] : m_stack[m_top];
		end else if (m_ctr[w][idx] >= 2) begin
			p.taken = 1'b1;
			p.next_pc = m_target[w][idx];
		end
	end
	return p;
endfunction

// One clock edge, every decision taken from the state before it
function automatic void advance_model(search_req_t s, update_req_t u, logic f);
	int sw;
	int uw;
	int sidx;
	int uidx;
	int new_ctr;
	logic tick;
	sidx = int'(s.pc[4:2]);
	uidx = int'(u.pc[4:2]);
	sw = s.valid ? find_way(s.pc) : -1;
	uw = find_way(u.pc);
	tick = (m_timer == (1 << LRU_AGE_BITS) - 1);
	if (uw >= 0) begin
		new_ctr = u.taken ? ((m_ctr[uw][uidx] < 3) ? m_ctr[uw][uidx] + 1 : 3)
			: ((m_ctr[uw][uidx] > 0) ? m_ctr[uw][uidx] - 1 : 0);
	end else begin
		new_ctr = u.taken ? 2 : 1;
		if (m_state[0][uidx] == LRU_EMPTY) uw = 0;
		else if (m_state[1][uidx] == LRU_EMPTY) uw = 1;
		else uw = (m_state[0][uidx] <= m_state[1][uidx]) ? 0 : 1;
	end
	if (f) begin
		m_top = 0;
		m_count = 0;
		clear_model();
	end else begin
		if (sw >= 0 && m_kind[sw][sidx] == BR_CALL) begin
			m_top = (m_top + 1) % RAS_DEPTH;
			m_stack[m_top] = s.pc + 32'd4;
			if (m_count < RAS_DEPTH) m_count++;
		end else if (sw >= 0 && m_kind[sw][sidx] == BR_RET && m_count > 0) begin
			m_top = (m_top + RAS_DEPTH - 1) % RAS_DEPTH;
			m_count--;
		end
		for (int i = 0; i < BTC_SETS; i++) begin
			for (int w = 0; w < 2; w++) begin
				if (u.valid && i == uidx && w == uw) begin
					m_state[w][i] = LRU_NEW;
				end else if (sw >= 0 && i == sidx && w == sw) begin
					if (m_state[w][i] == LRU_OLD) m_state[w][i] = LRU_MID;
					else if (m_state[w][i] == LRU_MID) m_state[w][i] = LRU_NEW;
				end else if (tick) begin
					if (m_state[w][i] == LRU_NEW) m_state[w][i] = LRU_MID;
					else if (m_state[w][i] == LRU_MID) m_state[w][i] = LRU_OLD;
				end
			end
		end
		if (u.valid) begin
			m_tag[uw][uidx] = u.pc[31:5];
			m_ctr[uw][uidx] = new_ctr;
			m_kind[uw][uidx] = u.kind;
			m_target[uw][uidx] = u.target;
		end
		m_timer = (m_timer + 1) % (1 << LRU_AGE_BITS);
	end
endfunction

`endif

// ==== testbench/tb_branch_predict_unit.sv ====
module tb_branch_predict_unit;
	import bpu_pkg::*;

	localparam int RESET_CYCLES = 16;
	localparam int DIRECTED_CYCLES = 400;
	localparam int RANDOM_CYCLES = 4000;
	localparam int TOTAL_CYCLES = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES;

	logic iCLOCK;
	logic inRESET;
	logic flush;
	search_req_t search;
	update_req_t update;
	prediction_t prediction;

	// Snapshot of the DUT output at the sampling point of the last cycle
	prediction_t seen;
	addr_t pc_pool [12];
	addr_t call_pc [5];

	`include "bpu_model.svh"

	branch_predict_unit branch_predict_unit_inst (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.flush(flush),
		.search(search),
		.update(update),
		.prediction(prediction)
	);

	initial iCLOCK = 1'b0;
	always #5 iCLOCK = ~iCLOCK;

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("[FAIL] t=%0t %s got=0x%08h expected=0x%08h", $time, name, got, exp);
			$display("Checks failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	function automatic addr_t make_pc(int tag, int idx);
		return {27'(tag), 3'(idx), 2'b00};
	endfunction

	// Drive at the falling edge and sample one unit later before stepping the model
	task automatic run_cycle(input search_req_t s, input update_req_t u, input logic f);
		prediction_t exp;
		search = s;
		update = u;
		flush = f;
		#1;
		exp = expect_prediction(s);
		seen = prediction;
		check_value("prediction.valid", 32'(prediction.valid), 32'(exp.valid));
		check_value("prediction.hit", 32'(prediction.hit), 32'(exp.hit));
		check_value("prediction.taken", 32'(prediction.taken), 32'(exp.taken));
		check_value("prediction.kind", 32'(prediction.kind), 32'(exp.kind));
		check_value("prediction.next_pc", prediction.next_pc, exp.next_pc);
		advance_model(s, u, f);
		@(negedge iCLOCK);
	endtask

	task automatic search_pc(input addr_t pc);
		search_req_t s;
		s.valid = 1'b1;
		s.pc = pc;
		run_cycle(s, '0, 1'b0);
	endtask

	task automatic write_branch(input addr_t pc, input logic taken, input branch_kind_e kind,
		input addr_t target);
		update_req_t u;
		u.valid = 1'b1;
		u.pc = pc;
		u.taken = taken;
		u.kind = kind;
		u.target = target;
		run_cycle('0, u, 1'b0);
	endtask

	task automatic random_mix(input int n);
		search_req_t s;
		update_req_t u;
		int r;
		for (int i = 0; i < n; i++) begin
			s.valid = ($urandom % 10) < 7;
			s.pc = pc_pool[int'($urandom % 12)];
			u.valid = ($urandom % 10) < 4;
			u.pc = pc_pool[int'($urandom % 12)];
			u.taken = 1'($urandom % 2);
			r = int'($urandom % 4);
			u.kind = (r == 0) ? BR_CALL : ((r == 1) ? BR_RET : BR_COND);
			u.target = $urandom & 32'hffff_fffc;
			run_cycle(s, u, ($urandom % 200) == 0);
		end
	endtask

	initial begin
		#((TOTAL_CYCLES + 100) * 10);
		$display("Timeout: the run did not finish within its cycle budget");
		$display("Checks failed");
		$fatal(1, "watchdog expired");
	end

	initial begin
		addr_t a;
		addr_t x;
		addr_t y;
		addr_t z;
		addr_t r;
		void'($urandom(18));
		inRESET = 1'b0;
		flush = 1'b0;
		search = '0;
		update = '0;
		// Sets 0 and 1 hold three tags each so random updates evict
		for (int i = 0; i < 12; i++) begin
			pc_pool[i] = make_pc(32'h1000 + i * 7, (i < 8) ? i : (i - 8) / 2);
		end
		repeat (RESET_CYCLES) @(negedge iCLOCK);
		inRESET = 1'b1;
		clear_model();

		// Empty cache misses everywhere
		for (int i = 0; i < 12; i++) begin
			search_pc(pc_pool[i]);
			check_value("prediction.hit", 32'(seen.hit), 32'd0);
			check_value("prediction.next_pc", seen.next_pc, pc_pool[i] + 32'd4);
		end

		// Counter walk with saturation at both ends
		a = make_pc(32'h2a5, 3);
		write_branch(a, 1'b1, BR_COND, 32'h0000_8000);
		search_pc(a);
		check_value("prediction.taken", 32'(seen.taken), 32'd1);
		repeat (3) begin
			write_branch(a, 1'b0, BR_COND, 32'h0000_8000);
			search_pc(a);
		end
		check_value("prediction.next_pc", seen.next_pc, a + 32'd4);
		repeat (4) begin
			write_branch(a, 1'b1, BR_COND, 32'h0000_8000);
			search_pc(a);
		end
		write_branch(a, 1'b0, BR_COND, 32'h0000_8000);
		search_pc(a);
		check_value("prediction.next_pc", seen.next_pc, 32'h0000_8000);

		// Three tags in set 5 where y ages below x and gets evicted
		x = make_pc(32'h111, 5);
		y = make_pc(32'h222, 5);
		z = make_pc(32'h333, 5);
		write_branch(x, 1'b1, BR_COND, 32'h0000_1100);
		write_branch(y, 1'b1, BR_COND, 32'h0000_2200);
		repeat (256) run_cycle('0, '0, 1'b0);
		search_pc(x);
		write_branch(z, 1'b0, BR_COND, 32'h0000_3300);
		search_pc(y);
		check_value("prediction.hit", 32'(seen.hit), 32'd0);
		search_pc(x);
		check_value("prediction.hit", 32'(seen.hit), 32'd1);
		search_pc(z);
		check_value("prediction.hit", 32'(seen.hit), 32'd1);

		// Calls and returns through the stack
		r = make_pc(32'h600, 7);
		write_branch(r, 1'b1, BR_RET, 32'h0000_4440);
		for (int i = 0; i < 5; i++) begin
			call_pc[i] = make_pc(32'h500 + i, i);
			write_branch(call_pc[i], 1'b1, BR_CALL, 32'h0001_0000 + i * 16);
		end
		search_pc(r);
		check_value("prediction.next_pc", seen.next_pc, 32'h0000_4440);
		search_pc(call_pc[0]);
		search_pc(r);
		check_value("prediction.next_pc", seen.next_pc, call_pc[0] + 32'd4);
		for (int i = 0; i < 5; i++) search_pc(call_pc[i]);
		// Oldest push was overwritten
		for (int i = 4; i >= 1; i--) begin
			search_pc(r);
			check_value("prediction.next_pc", seen.next_pc, call_pc[i] + 32'd4);
		end
		search_pc(r);
		check_value("prediction.next_pc", seen.next_pc, 32'h0000_4440);

		// Flush clears cache and stack
		search_pc(call_pc[0]);
		run_cycle('0, '0, 1'b1);
		for (int i = 0; i < 5; i++) begin
			search_pc(call_pc[i]);
			check_value("prediction.hit", 32'(seen.hit), 32'd0);
		end
		search_pc(a);
		check_value("prediction.hit", 32'(seen.hit), 32'd0);
		search_pc(x);
		check_value("prediction.hit", 32'(seen.hit), 32'd0);
		search_pc(z);
		check_value("prediction.hit", 32'(seen.hit), 32'd0);
		search_pc(r);
		check_value("prediction.hit", 32'(seen.hit), 32'd0);
		write_branch(r, 1'b1, BR_RET, 32'h0000_4440);
		search_pc(r);
		check_value("prediction.next_pc", seen.next_pc, 32'h0000_4440);

		random_mix(RANDOM_CYCLES);

		$display("All checks passed");
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+testbench
logic/bpu_pkg.sv
logic/branch_target_cache.sv
logic/return_stack.sv
logic/fetch_redirect.sv
logic/branch_predict_unit.sv
testbench/tb_branch_predict_unit.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build with Verilator, run, and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_branch_predict_unit \
	-f flist.f -o tb_sim || { echo "Verilator build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log
grep -q "Checks failed" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "All checks passed" sim.log && echo "Simulation passed" || { echo "No result in log"; exit 1; }
